//--- run.sh
#!/usr/bin/env bash
# compile and run the CPU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f vlog.f \
	--top-module cpu_tb \
	-Mdir obj_dir \
	-o cpu_tb_sim

# keep running past bound assertion errors so the testbench prints its summary
./obj_dir/cpu_tb_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu import cpu_pkg::*; (
	input  alu_op_e               op_i,
	input  logic [`WORD_SIZE-1:0] a_i,
	input  logic [`WORD_SIZE-1:0] b_i,
	output logic [`WORD_SIZE-1:0] result_o
);

	// carries out and overflow are dropped
	always_comb begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_PASS_B: result_o = b_i;
			// immediate byte into the upper half, low byte zero
			ALU_LHI: result_o = {b_i[7:0], 8'h00};
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_core import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_n,
	output logic                  imem_read_o,
	output logic [`WORD_SIZE-1:0] imem_addr_o,
	input  logic [`WORD_SIZE-1:0] imem_data_i,
	output logic                  dmem_read_o,
	output logic                  dmem_write_o,
	output logic [`WORD_SIZE-1:0] dmem_addr_o,
	output logic [`WORD_SIZE-1:0] dmem_wdata_o,
	input  logic [`WORD_SIZE-1:0] dmem_rdata_i,
	output logic [`WORD_SIZE-1:0] num_inst_o,
	output logic [`WORD_SIZE-1:0] output_port_o,
	output logic                  is_halted_o
);

	logic [`WORD_SIZE-1:0] pc;
	logic run_q;
	logic hlt_seen_q;
	inst_u if_id_inst;
	logic if_id_valid;

	ctrl_t id_ctrl;
	logic [`WORD_SIZE-1:0] id_imm;
	logic [`WORD_SIZE-1:0] rs_data;
	logic [`WORD_SIZE-1:0] rt_data;
	logic id_halt;
	logic stall;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;

	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	logic [`WORD_SIZE-1:0] mem_value;
	logic [`WORD_SIZE-1:0] wb_value;
	logic [`WORD_SIZE-1:0] ex_a;
	logic [`WORD_SIZE-1:0] ex_b;
	logic [`WORD_SIZE-1:0] alu_b;
	logic [`WORD_SIZE-1:0] alu_result;

	function automatic logic [`WORD_SIZE-1:0] fwd_pick(
		input logic [1:0]            sel,
		input logic [`WORD_SIZE-1:0] rf_val,
		input logic [`WORD_SIZE-1:0] mem_val,
		input logic [`WORD_SIZE-1:0] wb_val
	);
		case (sel)
			`FWD_MEM: fwd_pick = mem_val;
			`FWD_WB: fwd_pick = wb_val;
			default: fwd_pick = rf_val;
		endcase
	endfunction

	// fetch, stopped for good once HLT reaches ID
	assign id_halt = id_ctrl.halt;
	assign imem_read_o = run_q && !hlt_seen_q && !id_halt;
	assign imem_addr_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			run_q <= 1'b0;
			hlt_seen_q <= 1'b0;
			if_id_inst <= '0;
			if_id_valid <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (id_halt) begin
				hlt_seen_q <= 1'b1;
			end
			// stall holds both PC and IF/ID
			if (!stall) begin
				if (imem_read_o) begin
					pc <= pc + `WORD_SIZE'(1);
					if_id_inst <= imem_data_i;
					if_id_valid <= 1'b1;
				end else begin
					if_id_inst <= '0;
					if_id_valid <= 1'b0;
				end
			end
		end
	end

	decode_unit decode_i (
		.inst_i  (if_id_inst),
		.valid_i (if_id_valid),
		.ctrl_o  (id_ctrl),
		.imm_o   (id_imm)
	);

	register_file regs_i (
		.clk       (clk),
		.reset_n   (reset_n),
		.rs_addr_i (if_id_inst.r_view.rs),
		.rt_addr_i (if_id_inst.r_view.rt),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.wr_en_i   (mem_wb.ctrl.reg_write),
		.wr_addr_i (mem_wb.ctrl.dest),
		.wr_data_i (wb_value)
	);

	hazard_forward hazard_i (
		.id_inst_i  (if_id_inst),
		.ex_ctrl_i  (id_ex.ctrl),
		.mem_ctrl_i (ex_mem.ctrl),
		.wb_ctrl_i  (mem_wb.ctrl),
		.ex_rs_i    (id_ex.rs),
		.ex_rt_i    (id_ex.rt),
		.stall_o    (stall),
		.fwd_a_o    (fwd_a),
		.fwd_b_o    (fwd_b)
	);

	// bubble into EX on a load-use stall
	always_ff @(posedge clk) begin
		if (!reset_n || stall) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex.ctrl <= id_ctrl;
			id_ex.rs <= if_id_inst.r_view.rs;
			id_ex.rt <= if_id_inst.r_view.rt;
			id_ex.op_a <= rs_data;
			id_ex.op_b <= rt_data;
			id_ex.imm <= id_imm;
		end
	end

	// load data comes back in the MEM cycle itself
	assign mem_value = ex_mem.ctrl.mem_to_reg ? dmem_rdata_i : ex_mem.alu_result;
	assign wb_value = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

	assign ex_a = fwd_pick(fwd_a, id_ex.op_a, mem_value, wb_value);
	assign ex_b = fwd_pick(fwd_b, id_ex.op_b, mem_value, wb_value);
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_b;

	alu alu_i (
		.op_i     (id_ex.ctrl.alu_op),
		.a_i      (ex_a),
		.b_i      (alu_b),
		.result_o (alu_result)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_mem.ctrl <= '0;
		end else begin
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.alu_result <= alu_result;
			// WWD outputs rs, SWD stores rt
			ex_mem.store_data <= id_ex.ctrl.wwd ? ex_a : ex_b;
		end
	end

	assign dmem_read_o = ex_mem.ctrl.mem_read;
	assign dmem_write_o = ex_mem.ctrl.mem_write;
	assign dmem_addr_o = ex_mem.alu_result;
	assign dmem_wdata_o = ex_mem.store_data;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mem_wb.ctrl <= '0;
		end else begin
			mem_wb.ctrl <= ex_mem.ctrl;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.wwd_value <= ex_mem.store_data;
			mem_wb.load_data <= dmem_rdata_i;
		end
	end

	// retire side: counter, output port, halt latch
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_o <= '0;
			output_port_o <= '0;
			is_halted_o <= 1'b0;
		end else begin
			if (mem_wb.ctrl.valid) begin
				num_inst_o <= num_inst_o + `WORD_SIZE'(1);
			end
			if (mem_wb.ctrl.wwd) begin
				output_port_o <= mem_wb.wwd_value;
			end
			if (mem_wb.ctrl.halt) begin
				is_halted_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// machine word and register file size
`define WORD_SIZE 16
`define NUM_REGS 4

// opcodes of the supported instructions
`define ADI_OP 4'd4
`define ORI_OP 4'd5
`define LHI_OP 4'd6
`define LWD_OP 4'd7
`define SWD_OP 4'd8
`define ALU_OP 4'd15

// function codes under ALU_OP
`define FUNC_ADD 6'd0
`define FUNC_SUB 6'd1
`define FUNC_AND 6'd2
`define FUNC_ORR 6'd3
`define FUNC_WWD 6'd28
`define FUNC_HLT 6'd29

// operand source selects for EX
`define FWD_RF 2'd0
`define FWD_MEM 2'd1
`define FWD_WB 2'd2

`endif

//--- source/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// one instruction word, seen as R format or I format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			logic [5:0] func;
		} r_view;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} i_view;
	} inst_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B,
		ALU_LHI
	} alu_op_e;

	// control bits carried down the pipe
	typedef struct packed {
		alu_op_e alu_op;
		logic alu_src_imm;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic reg_write;
		logic [$clog2(`NUM_REGS)-1:0] dest;
		logic wwd;
		logic halt;
		logic valid;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [`WORD_SIZE-1:0] op_a;
		logic [`WORD_SIZE-1:0] op_b;
		logic [`WORD_SIZE-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`WORD_SIZE-1:0] alu_result;
		// SWD data, or the WWD value
		logic [`WORD_SIZE-1:0] store_data;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`WORD_SIZE-1:0] alu_result;
		logic [`WORD_SIZE-1:0] wwd_value;
		logic [`WORD_SIZE-1:0] load_data;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode_unit import cpu_pkg::*; (
	input  inst_u                 inst_i,
	input  logic                  valid_i,
	output ctrl_t                 ctrl_o,
	output logic [`WORD_SIZE-1:0] imm_o
);

	logic [7:0] imm8;
	logic [`WORD_SIZE-1:0] imm_sext;
	logic [`WORD_SIZE-1:0] imm_zext;

	assign imm8 = inst_i.i_view.imm;
	assign imm_sext = {{(`WORD_SIZE-8){imm8[7]}}, imm8};
	assign imm_zext = {{(`WORD_SIZE-8){1'b0}}, imm8};

	always_comb begin
		ctrl_o = '0;
		ctrl_o.alu_op = ALU_PASS_B;
		ctrl_o.valid = valid_i;
		// I format writes rt unless overridden below
		ctrl_o.dest = inst_i.i_view.rt;
		imm_o = imm_sext;
		if (valid_i) begin
			case (inst_i.r_view.opcode)
				`ALU_OP: begin
					ctrl_o.dest = inst_i.r_view.rd;
					case (inst_i.r_view.func)
						`FUNC_ADD: begin
							ctrl_o.alu_op = ALU_ADD;
							ctrl_o.reg_write = 1'b1;
						end
						`FUNC_SUB: begin
							ctrl_o.alu_op = ALU_SUB;
							ctrl_o.reg_write = 1'b1;
						end
						`FUNC_AND: begin
							ctrl_o.alu_op = ALU_AND;
							ctrl_o.reg_write = 1'b1;
						end
						`FUNC_ORR: begin
							ctrl_o.alu_op = ALU_OR;
							ctrl_o.reg_write = 1'b1;
						end
						`FUNC_WWD: ctrl_o.wwd = 1'b1;
						`FUNC_HLT: ctrl_o.halt = 1'b1;
						// unknown func retires as a no-op
						default: ;
					endcase
				end
				`ADI_OP: begin
					ctrl_o.alu_op = ALU_ADD;
					ctrl_o.alu_src_imm = 1'b1;
					ctrl_o.reg_write = 1'b1;
				end
				`ORI_OP: begin
					ctrl_o.alu_op = ALU_OR;
					ctrl_o.alu_src_imm = 1'b1;
					ctrl_o.reg_write = 1'b1;
					imm_o = imm_zext;
				end
				`LHI_OP: begin
					// ALU moves the byte up
					ctrl_o.alu_op = ALU_LHI;
					ctrl_o.alu_src_imm = 1'b1;
					ctrl_o.reg_write = 1'b1;
					imm_o = imm_zext;
				end
				`LWD_OP: begin
					ctrl_o.alu_op = ALU_ADD;
					ctrl_o.alu_src_imm = 1'b1;
					ctrl_o.mem_read = 1'b1;
					ctrl_o.mem_to_reg = 1'b1;
					ctrl_o.reg_write = 1'b1;
				end
				`SWD_OP: begin
					ctrl_o.alu_op = ALU_ADD;
					ctrl_o.alu_src_imm = 1'b1;
					ctrl_o.mem_write = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/hazard_forward.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module hazard_forward import cpu_pkg::*; (
	input  inst_u      id_inst_i,
	input  ctrl_t      ex_ctrl_i,
	input  ctrl_t      mem_ctrl_i,
	input  ctrl_t      wb_ctrl_i,
	input  logic [1:0] ex_rs_i,
	input  logic [1:0] ex_rt_i,
	output logic       stall_o,
	output logic [1:0] fwd_a_o,
	output logic [1:0] fwd_b_o
);

	logic is_alu;
	logic reads_rs;
	logic reads_rt;
	logic ex_load;
	logic mem_wr;
	logic wb_wr;

	// which sources the ID instruction really uses
	assign is_alu = id_inst_i.r_view.opcode == `ALU_OP;
	assign reads_rs = (is_alu && id_inst_i.r_view.func != `FUNC_HLT)
		|| id_inst_i.i_view.opcode inside {`ADI_OP, `ORI_OP, `LWD_OP, `SWD_OP};
	assign reads_rt = (is_alu && id_inst_i.r_view.func <= `FUNC_ORR)
		|| id_inst_i.i_view.opcode == `SWD_OP;

	assign ex_load = ex_ctrl_i.valid && ex_ctrl_i.mem_read && ex_ctrl_i.reg_write;
	assign stall_o = ex_load
		&& ((reads_rs && ex_ctrl_i.dest == id_inst_i.r_view.rs)
		|| (reads_rt && ex_ctrl_i.dest == id_inst_i.r_view.rt));

	assign mem_wr = mem_ctrl_i.valid && mem_ctrl_i.reg_write;
	assign wb_wr = wb_ctrl_i.valid && wb_ctrl_i.reg_write;

	// nearest producer wins
	always_comb begin
		fwd_a_o = `FWD_RF;
		if (mem_wr && mem_ctrl_i.dest == ex_rs_i) begin
			fwd_a_o = `FWD_MEM;
		end else if (wb_wr && wb_ctrl_i.dest == ex_rs_i) begin
			fwd_a_o = `FWD_WB;
		end
		fwd_b_o = `FWD_RF;
		if (mem_wr && mem_ctrl_i.dest == ex_rt_i) begin
			fwd_b_o = `FWD_MEM;
		end else if (wb_wr && wb_ctrl_i.dest == ex_rt_i) begin
			fwd_b_o = `FWD_WB;
		end
	end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module register_file #(
	parameter int ADDR_W = $clog2(`NUM_REGS)
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic [ADDR_W-1:0]     rs_addr_i,
	input  logic [ADDR_W-1:0]     rt_addr_i,
	output logic [`WORD_SIZE-1:0] rs_data_o,
	output logic [`WORD_SIZE-1:0] rt_data_o,
	input  logic                  wr_en_i,
	input  logic [ADDR_W-1:0]     wr_addr_i,
	input  logic [`WORD_SIZE-1:0] wr_data_i
);

	logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// WB write seen by the ID read in the same cycle
	assign rs_data_o = (wr_en_i && wr_addr_i == rs_addr_i) ? wr_data_i : regs[rs_addr_i];
	assign rt_data_o = (wr_en_i && wr_addr_i == rt_addr_i) ? wr_data_i : regs[rt_addr_i];

endmodule

`default_nettype wire

//--- verif/cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_chk (
	input logic                  clk,
	input logic                  reset_n,
	input logic                  imem_read_i,
	input logic                  dmem_read_i,
	input logic                  dmem_write_i,
	input logic                  is_halted_i,
	input logic [`WORD_SIZE-1:0] num_inst_i,
	input logic [`WORD_SIZE-1:0] output_port_i
);

	int unsigned fails = 0;

	// quiet outputs during reset and on the edge after it
	reset_quiet: assert property (@(posedge clk)
		!reset_n |=> !imem_read_i && !dmem_read_i && !dmem_write_i && !is_halted_i
			&& num_inst_i == '0 && output_port_i == '0)
	else begin
		fails++;
		$error("core outputs active in reset");
	end

	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> is_halted_i)
	else begin
		fails++;
		$error("halt dropped");
	end

	// nothing fetched or stored once halted
	halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |-> !dmem_write_i && !imem_read_i)
	else begin
		fails++;
		$error("memory access after halt");
	end

	halt_frozen: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> $stable(output_port_i) && $stable(num_inst_i))
	else begin
		fails++;
		$error("output port or retire count moved after halt");
	end

endmodule

bind cpu_core cpu_chk chk_i (
	.clk           (clk),
	.reset_n       (reset_n),
	.imem_read_i   (imem_read_o),
	.dmem_read_i   (dmem_read_o),
	.dmem_write_i  (dmem_write_o),
	.is_halted_i   (is_halted_o),
	.num_inst_i    (num_inst_o),
	.output_port_i (output_port_o)
);

`default_nettype wire

//--- verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

	logic clk = 1'b0;
	logic reset_n;
	logic imem_read;
	logic dmem_read;
	logic dmem_write;
	logic is_halted;
	logic [`WORD_SIZE-1:0] imem_addr;
	logic [`WORD_SIZE-1:0] imem_data;
	logic [`WORD_SIZE-1:0] dmem_addr;
	logic [`WORD_SIZE-1:0] dmem_wdata;
	logic [`WORD_SIZE-1:0] dmem_rdata;
	logic [`WORD_SIZE-1:0] num_inst;
	logic [`WORD_SIZE-1:0] output_port;

	logic [`WORD_SIZE-1:0] imem [256];
	logic [`WORD_SIZE-1:0] dmem [256];
	logic [`WORD_SIZE-1:0] model_mem [256];
	logic [`WORD_SIZE-1:0] exp_out [$];
	logic [`WORD_SIZE-1:0] last_port = '0;
	int prog_len = 0;
	int model_count = 0;
	int out_idx = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 1000;

	always #2 clk = ~clk;

	cpu_core dut_i (
		.clk           (clk),
		.reset_n       (reset_n),
		.imem_read_o   (imem_read),
		.imem_addr_o   (imem_addr),
		.imem_data_i   (imem_data),
		.dmem_read_o   (dmem_read),
		.dmem_write_o  (dmem_write),
		.dmem_addr_o   (dmem_addr),
		.dmem_wdata_o  (dmem_wdata),
		.dmem_rdata_i  (dmem_rdata),
		.num_inst_o    (num_inst),
		.output_port_o (output_port),
		.is_halted_o   (is_halted)
	);

	// both memories answer in the same cycle
	assign imem_data = imem[imem_addr[7:0]];
	// read data only while the core asks for it
	assign dmem_rdata = dmem_read ? dmem[dmem_addr[7:0]] : '0;

	always @(posedge clk) begin
		if (dmem_write) begin
			dmem[dmem_addr[7:0]] <= dmem_wdata;
		end
	end

	task automatic check_that(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERR %0t: %s", $time, msg);
		end
	endtask

	function automatic logic [15:0] r_word(input logic [1:0] rs, input logic [1:0] rt,
		input logic [1:0] rd, input logic [5:0] func);
		return {`ALU_OP, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] i_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic put_inst(input logic [15:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic build_program();
		logic [7:0] k1;
		logic [7:0] k2;
		logic [7:0] k3;
		k1 = 8'($urandom());
		// bit 7 set so zero and sign extension differ
		k2 = 8'($urandom()) | 8'h80;
		k3 = 8'($urandom()) | 8'h80;
		// unused words never get fetched
		for (int a = 0; a < 256; a++) begin
			imem[a] = {8'hA5 ^ 8'(a), 8'(a)};
		end
		put_inst(i_word(`LHI_OP, 2'd0, 2'd1, k1));
		put_inst(i_word(`ORI_OP, 2'd1, 2'd1, k2));
		put_inst(i_word(`ADI_OP, 2'd0, 2'd2, k3));
		put_inst(r_word(2'd1, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(r_word(2'd1, 2'd2, 2'd3, `FUNC_ADD));
		put_inst(r_word(2'd3, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(r_word(2'd3, 2'd1, 2'd3, `FUNC_SUB));
		put_inst(r_word(2'd3, 2'd2, 2'd0, `FUNC_AND));
		put_inst(r_word(2'd0, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(r_word(2'd0, 2'd1, 2'd2, `FUNC_ORR));
		put_inst(r_word(2'd2, 2'd0, 2'd0, `FUNC_WWD));
		// r0 becomes the data base address
		put_inst(i_word(`LHI_OP, 2'd0, 2'd0, 8'h00));
		put_inst(i_word(`ORI_OP, 2'd0, 2'd0, 8'h40));
		put_inst(i_word(`LWD_OP, 2'd0, 2'd1, 8'h03));
		put_inst(r_word(2'd1, 2'd1, 2'd2, `FUNC_ADD));
		put_inst(r_word(2'd2, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(i_word(`SWD_OP, 2'd0, 2'd1, 8'h05));
		put_inst(i_word(`LWD_OP, 2'd0, 2'd3, 8'h05));
		put_inst(r_word(2'd3, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(i_word(`LWD_OP, 2'd0, 2'd1, 8'hFE));
		put_inst(i_word(`SWD_OP, 2'd0, 2'd1, 8'h07));
		put_inst(r_word(2'd1, 2'd3, 2'd2, `FUNC_SUB));
		put_inst(r_word(2'd2, 2'd0, 2'd0, `FUNC_WWD));
		put_inst(r_word(2'd0, 2'd0, 2'd0, `FUNC_HLT));
	endtask

	// one instruction at a time, no pipeline
	task automatic run_reference();
		logic [15:0] r [4];
		logic [15:0] w;
		logic [15:0] addr;
		logic [15:0] prev;
		logic done;
		int pc;
		for (int i = 0; i < 4; i++) begin
			r[i] = '0;
		end
		prev = '0;
		done = 1'b0;
		pc = 0;
		while (!done && pc < 256) begin
			w = imem[pc];
			pc++;
			model_count++;
			addr = r[w[11:10]] + {{8{w[7]}}, w[7:0]};
			case (w[15:12])
				`ALU_OP: begin
					case (w[5:0])
						`FUNC_ADD: r[w[7:6]] = r[w[11:10]] + r[w[9:8]];
						`FUNC_SUB: r[w[7:6]] = r[w[11:10]] - r[w[9:8]];
						`FUNC_AND: r[w[7:6]] = r[w[11:10]] & r[w[9:8]];
						`FUNC_ORR: r[w[7:6]] = r[w[11:10]] | r[w[9:8]];
						`FUNC_WWD: begin
							// a repeated value leaves the port unchanged
							if (r[w[11:10]] != prev) begin
								exp_out.push_back(r[w[11:10]]);
							end
							prev = r[w[11:10]];
						end
						`FUNC_HLT: done = 1'b1;
						default: ;
					endcase
				end
				`ADI_OP: r[w[9:8]] = addr;
				`ORI_OP: r[w[9:8]] = r[w[11:10]] | {8'h00, w[7:0]};
				`LHI_OP: r[w[9:8]] = {w[7:0], 8'h00};
				`LWD_OP: r[w[9:8]] = model_mem[addr[7:0]];
				`SWD_OP: model_mem[addr[7:0]] = r[w[9:8]];
				default: ;
			endcase
		end
	endtask

	// every change of the output port against the expected sequence
	always @(posedge clk) begin
		if (reset_n === 1'b1 && output_port != last_port) begin
			if (out_idx < exp_out.size()) begin
				check_that(output_port == exp_out[out_idx],
					$sformatf("output port %h, expected %h", output_port, exp_out[out_idx]));
			end else begin
				check_that(1'b0, $sformatf("output port changed to %h after the last WWD",
					output_port));
			end
			out_idx++;
			last_port <= output_port;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the CPU did not halt within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int mark;
		int chk_fails;
		reset_n = 1'b0;
		void'($urandom(8463));
		build_program();
		for (int a = 0; a < 256; a++) begin
			dmem[a] = 16'($urandom());
			model_mem[a] = dmem[a];
		end
		run_reference();
		cycle_limit = 4 * prog_len + 50;

		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		while (is_halted !== 1'b1) begin
			@(posedge clk);
		end

		check_that(out_idx == exp_out.size(),
			$sformatf("%0d of %0d WWD values seen at halt", out_idx, exp_out.size()));
		$display("test wwd sequence: %0d values, %0d errors", out_idx, errors);

		mark = errors;
		check_that(num_inst == 16'(model_count),
			$sformatf("retire count %0d, expected %0d", num_inst, model_count));
		$display("test retire count: %0d errors", errors - mark);

		mark = errors;
		for (int a = 0; a < 256; a++) begin
			check_that(dmem[a] == model_mem[a],
				$sformatf("data word %0d is %h, expected %h", a, dmem[a], model_mem[a]));
		end
		$display("test data memory: %0d errors", errors - mark);

		// halted core must stay frozen
		repeat (10) @(posedge clk);
		chk_fails = dut_i.chk_i.fails;
		$display("test reset and halt hold: %0d assertion failures", chk_fails);

		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/decode_unit.sv
source/register_file.sv
source/hazard_forward.sv
source/cpu_core.sv
verif/cpu_chk.sv
verif/cpu_tb.sv
